//--- src/mipsAluPkg.sv
package mipsAluPkg;

    ////////////////////
    // Widths
    ////////////////////
    localparam int DataW  = 32;
    localparam int AddrW  = 5;     // APB offset bits
    localparam int ShamtW = 5;     // MIPS shamt field

    ////////////////////
    // ALU control codes
    ////////////////////
    typedef enum logic [3:0] {
        aluClear = 4'd0,    // Also used for illegal instructions
        aluAdd   = 4'd1,
        aluSub   = 4'd2,
        aluMul   = 4'd3,    // Low half of product only
        aluSge   = 4'd4,
        aluSne   = 4'd5,
        aluSgt   = 4'd6,
        aluSle   = 4'd7,
        aluSlt   = 4'd8,
        aluAnd   = 4'd10,   // Code 9 left unused
        aluOr    = 4'd11,
        aluNor   = 4'd12,
        aluXor   = 4'd13,
        aluSll   = 4'd14,
        aluSrl   = 4'd15
    } aluCtrlT;

    // Primary opcodes in instr[31:26]
    localparam logic [5:0] OpRType    = 6'h00;
    localparam logic [5:0] OpSge      = 6'h01;
    localparam logic [5:0] OpSne      = 6'h05;
    localparam logic [5:0] OpSle      = 6'h06;
    localparam logic [5:0] OpSgt      = 6'h07;
    localparam logic [5:0] OpSpecial2 = 6'h1C;

    // Function codes in instr[5:0]
    localparam logic [5:0] FnSll  = 6'h00;
    localparam logic [5:0] FnSrl  = 6'h02;
    localparam logic [5:0] FnAdd  = 6'h20;
    localparam logic [5:0] FnAddu = 6'h21;
    localparam logic [5:0] FnSub  = 6'h22;
    localparam logic [5:0] FnAnd  = 6'h24;
    localparam logic [5:0] FnOr   = 6'h25;
    localparam logic [5:0] FnXor  = 6'h26;
    localparam logic [5:0] FnNor  = 6'h27;
    localparam logic [5:0] FnSlt  = 6'h2A;
    localparam logic [5:0] FnMul  = 6'h02;   // Only under OpSpecial2

    ////////////////////
    // Register map
    ////////////////////
    localparam logic [AddrW-1:0] RegOpA    = 5'h00;
    localparam logic [AddrW-1:0] RegOpB    = 5'h04;
    localparam logic [AddrW-1:0] RegInstr  = 5'h08;  // Write issues
    localparam logic [AddrW-1:0] RegResult = 5'h0C;  // Read only
    localparam logic [AddrW-1:0] RegStatus = 5'h10;  // Read only
    localparam logic [AddrW-1:0] RegCount  = 5'h14;  // Read only

    // Status register bits
    localparam int StZero    = 0;
    localparam int StDone    = 1;
    localparam int StIllegal = 2;

endpackage

//--- src/aluOpIf.sv
// One decoded operation from decode to execute
interface aluOpIf;
    import mipsAluPkg::*;

    logic              valid;    // Single-cycle pulse per issue
    aluCtrlT           ctrl;
    logic [DataW-1:0]  a;
    logic [DataW-1:0]  b;
    logic [ShamtW-1:0] shamt;
    logic              illegal;  // Decode failed and ctrl is clear

    modport driver (
        output valid, ctrl, a, b, shamt, illegal
    );

    modport receiver (
        input valid, ctrl, a, b, shamt, illegal
    );

endinterface

//--- src/aluResultIf.sv
// Captured result and status from result stage back to decode
interface aluResultIf;
    import mipsAluPkg::*;

    logic [DataW-1:0] result;
    logic             zero;     // Result equals 0
    logic             done;
    logic             illegal;  // Last captured op was illegal
    logic [DataW-1:0] count;    // Completed operations

    modport driver (
        output result, zero, done, illegal, count
    );

    modport receiver (
        input result, zero, done, illegal, count
    );

endinterface

//--- src/aluDecode.sv
module aluDecode (
    input  logic                         Clk,
    input  logic                         rstN,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [mipsAluPkg::AddrW-1:0] paddr,
    input  logic [mipsAluPkg::DataW-1:0] pwdata,
    output logic [mipsAluPkg::DataW-1:0] prdata,
    output logic                         pslverr,
    aluOpIf.driver                       op,
    aluResultIf.receiver                 res
);
    import mipsAluPkg::*;

    logic              access;
    logic              wrAccess;
    logic              issueNow;
    logic              mapped;
    logic              readOnly;
    logic [DataW-1:0]  opA;
    logic [DataW-1:0]  opB;
    logic [DataW-1:0]  instrReg;
    logic [DataW-1:0]  status;
    logic [5:0]        opcode;
    logic [5:0]        funct;
    logic [ShamtW-1:0] shamt;
    aluCtrlT           decCtrl;
    logic              decIllegal;

    assign access   = psel && penable;   // APB access phase with pready always 1
    assign wrAccess = access && pwrite;
    assign issueNow = wrAccess && (paddr == RegInstr);

    // MIPS fields straight off the write bus
    assign opcode = pwdata[31:26];
    assign shamt  = pwdata[10:6];
    assign funct  = pwdata[5:0];

    ////////////////////
    // Instruction decode
    ////////////////////
    always_comb begin
        decCtrl    = aluClear;
        decIllegal = 1'b0;
        case (opcode)
            OpRType: begin
                case (funct)
                    FnSll:         decCtrl = aluSll;
                    FnSrl:         decCtrl = aluSrl;
                    FnAdd, FnAddu: decCtrl = aluAdd;   // No overflow trap
                    FnSub:         decCtrl = aluSub;
                    FnAnd:         decCtrl = aluAnd;
                    FnOr:          decCtrl = aluOr;
                    FnXor:         decCtrl = aluXor;
                    FnNor:         decCtrl = aluNor;
                    FnSlt:         decCtrl = aluSlt;
                    default:       decIllegal = 1'b1;
                endcase
            end
            OpSpecial2: begin
                if (funct == FnMul) begin
                    decCtrl = aluMul;
                end else begin
                    decIllegal = 1'b1;
                end
            end
            OpSge:   decCtrl = aluSge;
            OpSne:   decCtrl = aluSne;
            OpSle:   decCtrl = aluSle;
            OpSgt:   decCtrl = aluSgt;
            default: decIllegal = 1'b1;
        endcase
    end

    // Address map classification
    always_comb begin
        mapped   = 1'b1;
        readOnly = 1'b0;
        case (paddr)
            RegOpA, RegOpB, RegInstr:       readOnly = 1'b0;
            RegResult, RegStatus, RegCount: readOnly = 1'b1;
            default:                        mapped   = 1'b0;
        endcase
    end

    assign pslverr = access && (!mapped || (pwrite && readOnly) ||
                                (issueNow && decIllegal));

    // Host-visible registers
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            opA      <= '0;
            opB      <= '0;
            instrReg <= '0;
        end else if (wrAccess) begin
            case (paddr)
                RegOpA:   opA      <= pwdata;
                RegOpB:   opB      <= pwdata;
                RegInstr: instrReg <= pwdata;  // Kept even when illegal
                default:  ;
            endcase
        end
    end

    ////////////////////
    // Issue to execute
    ////////////////////
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            op.valid <= 1'b0;
        end else begin
            op.valid <= issueNow;   // One pulse per instruction write
        end
    end

    always_ff @(posedge Clk) begin
        if (issueNow) begin
            op.ctrl    <= decCtrl;
            op.a       <= opA;
            op.b       <= opB;
            op.shamt   <= shamt;
            op.illegal <= decIllegal;
        end
    end

    // Readback
    always_comb begin
        status            = '0;
        status[StZero]    = res.zero;
        status[StDone]    = res.done;
        status[StIllegal] = res.illegal;
    end

    always_comb begin
        case (paddr)
            RegOpA:    prdata = opA;
            RegOpB:    prdata = opB;
            RegInstr:  prdata = instrReg;
            RegResult: prdata = res.result;
            RegStatus: prdata = status;
            RegCount:  prdata = res.count;
            default:   prdata = '0;
        endcase
    end

endmodule

//--- src/aluExecute.sv
module aluExecute (
    input  logic                         Clk,
    input  logic                         rstN,
    aluOpIf.receiver                     op,
    output logic                         resValid,
    output logic [mipsAluPkg::DataW-1:0] resData,
    output logic                         resIllegal
);
    import mipsAluPkg::*;

    logic [DataW-1:0] aluOut;
    logic             diffSign;
    logic             eq;
    logic             signLt;

    // Signed compare via sign bits and magnitude when signs agree
    assign diffSign = op.a[DataW-1] ^ op.b[DataW-1];
    assign eq       = (op.a == op.b);
    assign signLt   = diffSign ? op.a[DataW-1] : (op.a < op.b);  // Negative a wins

    ////////////////////
    // ALU
    ////////////////////
    always_comb begin
        case (op.ctrl)
            aluClear: aluOut = '0;
            aluAdd:   aluOut = op.a + op.b;
            aluSub:   aluOut = op.a - op.b;
            aluMul:   aluOut = op.a * op.b;          // Upper half dropped
            aluSge:   aluOut = DataW'(!signLt);
            aluSne:   aluOut = DataW'(!eq);
            aluSgt:   aluOut = DataW'(!signLt && !eq);
            aluSle:   aluOut = DataW'(signLt || eq);
            aluSlt:   aluOut = DataW'(signLt);
            aluAnd:   aluOut = op.a & op.b;
            aluOr:    aluOut = op.a | op.b;
            aluNor:   aluOut = ~(op.a | op.b);
            aluXor:   aluOut = op.a ^ op.b;
            aluSll:   aluOut = op.b << op.shamt;     // Shifts act on b
            aluSrl:   aluOut = op.b >> op.shamt;     // Logical with zero fill
            default:  aluOut = '0;
        endcase
    end

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            resValid <= 1'b0;
        end else begin
            resValid <= op.valid;
        end
    end

    // Payload only moves with a valid op
    always_ff @(posedge Clk) begin
        if (op.valid) begin
            resData    <= aluOut;
            resIllegal <= op.illegal;
        end
    end

endmodule

//--- src/aluResult.sv
module aluResult (
    input  logic                         Clk,
    input  logic                         rstN,
    input  logic                         resValid,
    input  logic [mipsAluPkg::DataW-1:0] resData,
    input  logic                         resIllegal,
    input  logic                         issue,     // Decode op valid
    aluResultIf.driver                   res
);
    import mipsAluPkg::*;

    // Zero follows the captured value so reset gives zero set
    assign res.zero = (res.result == '0);

    ////////////////////
    // Capture
    ////////////////////
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            res.result  <= '0;
            res.illegal <= 1'b0;
            res.count   <= '0;
        end else if (resValid) begin
            res.result  <= resData;
            res.illegal <= resIllegal;            // Latched per operation
            res.count   <= res.count + DataW'(1); // Wraps at 2^32
        end
    end

    // Done drops on issue and rises on capture
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            res.done <= 1'b0;
        end else if (issue) begin
            res.done <= 1'b0;    // Newer op still in flight
        end else if (resValid) begin
            res.done <= 1'b1;
        end
    end

endmodule

//--- src/mipsAluTop.sv
module mipsAluTop (
    input  logic                         Clk,
    input  logic                         rstN,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [mipsAluPkg::AddrW-1:0] paddr,
    input  logic [mipsAluPkg::DataW-1:0] pwdata,
    output logic [mipsAluPkg::DataW-1:0] prdata,
    output logic                         pready,
    output logic                         pslverr
);
    import mipsAluPkg::*;

    logic             resValid;
    logic             resIllegal;
    logic [DataW-1:0] resData;

    aluOpIf     opBus ();
    aluResultIf resBus ();

    assign pready = 1'b1;   // No wait states

    // APB slave and decode
    aluDecode i_aluDecode (
        .Clk     (Clk),
        .rstN    (rstN),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pslverr (pslverr),
        .op      (opBus.driver),
        .res     (resBus.receiver)
    );

    aluExecute i_aluExecute (
        .Clk        (Clk),
        .rstN       (rstN),
        .op         (opBus.receiver),
        .resValid   (resValid),
        .resData    (resData),
        .resIllegal (resIllegal)
    );

    aluResult i_aluResult (
        .Clk        (Clk),
        .rstN       (rstN),
        .resValid   (resValid),
        .resData    (resData),
        .resIllegal (resIllegal),
        .issue      (opBus.valid),   // Clears done
        .res        (resBus.driver)
    );

endmodule

//--- bench/mipsAlu_assertions.sv
module mipsAluAssertions (
    input logic                         Clk,
    input logic                         rstN,
    input logic                         psel,
    input logic                         penable,
    input logic                         pwrite,
    input logic [mipsAluPkg::AddrW-1:0] paddr,
    input logic                         pslverr,
    input logic                         opValid
);
    import mipsAluPkg::*;

    logic access;
    logic instrWr;

    assign access  = psel && penable;
    assign instrWr = access && pwrite && (paddr == RegInstr);   // Issue edge

    ////////////////////
    // APB
    ////////////////////
    pslverrInAccess: assert property (@(posedge Clk) disable iff (!rstN)
        pslverr |-> access)
        else $error("pslverr high outside an access phase");

    // Decode to execute handoff
    issueFollows: assert property (@(posedge Clk) disable iff (!rstN)
        instrWr |=> opValid)
        else $error("instruction write not followed by op valid");

    singlePulse: assert property (@(posedge Clk) disable iff (!rstN)
        (opValid && !instrWr) |=> !opValid)
        else $error("op valid held longer than one cycle");

endmodule

bind aluDecode mipsAluAssertions i_mipsAluAssertions (
    .Clk     (Clk),
    .rstN    (rstN),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pslverr (pslverr),
    .opValid (op.valid)
);

//--- bench/mipsAluTb.sv
module mipsAluTb;
    import mipsAluPkg::*;

    typedef struct packed {
        logic [DataW-1:0] a;
        logic [DataW-1:0] b;
        logic [DataW-1:0] instr;
        logic [DataW-1:0] expResult;
        logic             expErr;     // pslverr on the instruction write
        logic             illegal;
    } rowT;

    localparam int TimeoutCycles = 20;
    localparam int RandomRows    = 16;

    logic             Clk;
    logic             rstN;
    logic             psel;
    logic             penable;
    logic             pwrite;
    logic [AddrW-1:0] paddr;
    logic [DataW-1:0] pwdata;
    logic [DataW-1:0] prdata;
    logic             pready;
    logic             pslverr;

    rowT              rows[$];
    int               nLegal;         // Legal rows come first in the table
    int               errors;
    int               checks;
    int               issued;
    logic [DataW-1:0] lastInstr;
    logic [DataW-1:0] rdData;         // Captured mid access phase
    logic             rdErr;

    mipsAluTop i_mipsAluTop (.*);

    initial Clk = 1'b0;
    always #2 Clk = ~Clk;

    ////////////////////
    // Helpers
    ////////////////////
    function automatic logic [DataW-1:0] mkInstr(input logic [5:0] opc,
                                                 input logic [4:0] sh, input logic [5:0] fn);
        return {opc, 15'd0, sh, fn};   // rs, rt, rd unused
    endfunction

    // Model built straight from the ISA fields
    function automatic logic [DataW-1:0] refAlu(input logic [DataW-1:0] a, b, instr,
                                                output logic illegal);
        logic [5:0]       opc;
        logic [5:0]       fn;
        logic [4:0]       sh;
        logic [DataW-1:0] r;
        opc     = instr[31:26];
        sh      = instr[10:6];
        fn      = instr[5:0];
        illegal = 1'b0;
        r       = '0;
        case (opc)
            OpRType: begin
                case (fn)
                    FnAdd, FnAddu: r = a + b;
                    FnSub:         r = a - b;
                    FnAnd:         r = a & b;
                    FnOr:          r = a | b;
                    FnXor:         r = a ^ b;
                    FnNor:         r = ~(a | b);
                    FnSlt:         r = ($signed(a) < $signed(b));
                    FnSll:         r = b << sh;
                    FnSrl:         r = b >> sh;
                    default:       illegal = 1'b1;
                endcase
            end
            OpSpecial2: begin
                if (fn == FnMul) begin
                    r = a * b;
                end else begin
                    illegal = 1'b1;
                end
            end
            OpSge:   r = ($signed(a) >= $signed(b));
            OpSgt:   r = ($signed(a) > $signed(b));
            OpSle:   r = ($signed(a) <= $signed(b));
            OpSne:   r = (a != b);
            default: illegal = 1'b1;
        endcase
        return r;
    endfunction

    task automatic checkEq(input string name, input logic [DataW-1:0] got,
                           input logic [DataW-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // One APB transfer starting and ending 1 unit after a rising edge
    task automatic apbXfer(input logic wr, input logic [AddrW-1:0] addr,
                           input logic [DataW-1:0] wdata);
        int waitCnt;
        waitCnt = 0;
        psel    = 1'b1;       // Setup phase
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge Clk);
        #1 penable = 1'b1;    // Access phase
        #1;
        while (pready !== 1'b1 && waitCnt < TimeoutCycles) begin
            @(posedge Clk);
            #2;
            waitCnt++;
        end
        if (pready !== 1'b1) begin
            errors++;
            $display("APB transfer to offset %h never got pready", addr);
        end
        rdData = prdata;
        rdErr  = pslverr;
        @(posedge Clk);
        #1 psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apbWrite(input logic [AddrW-1:0] addr, input logic [DataW-1:0] data,
                            input logic expErr);
        apbXfer(1'b1, addr, data);
        checkEq($sformatf("pslverr on write %h", addr), rdErr, expErr);
    endtask

    task automatic apbRead(input logic [AddrW-1:0] addr, input logic [DataW-1:0] exp);
        apbXfer(1'b0, addr, '0);
        checkEq($sformatf("prdata at %h", addr), rdData, exp);
        checkEq($sformatf("pslverr on read %h", addr), rdErr, 1'b0);
    endtask

    task automatic addRow(input logic [DataW-1:0] a, b, instr, exp, input logic ill);
        rows.push_back('{a, b, instr, exp, ill, ill});
    endtask

    // Operands, issue, poll done, then status and result
    task automatic runRow(input rowT row);
        int polls;
        polls = 0;
        apbWrite(RegOpA, row.a, 1'b0);
        apbWrite(RegOpB, row.b, 1'b0);
        apbWrite(RegInstr, row.instr, row.expErr);
        issued++;
        lastInstr = row.instr;
        repeat (2) @(posedge Clk);   // Access phase starts 3 cycles after issue edge
        #1;
        apbXfer(1'b0, RegStatus, '0);
        checkEq("status.done at fixed latency", rdData[StDone], 1'b1);
        while (!rdData[StDone] && polls < TimeoutCycles) begin
            apbXfer(1'b0, RegStatus, '0);
            polls++;
        end
        if (!rdData[StDone]) begin
            errors++;
            $display("Timed out waiting for done, instruction %h", row.instr);
        end
        checkEq("status", rdData, {row.illegal, 1'b1, row.expResult == '0});
        apbRead(RegResult, row.expResult);
    endtask

    ////////////////////
    // Stimulus table
    ////////////////////
    task automatic buildTable();
        addRow(32'd5,         32'd7,         mkInstr(OpRType, 0, FnAdd),  32'd12,        0);
        addRow(32'hFFFF_FFFF, 32'd1,         mkInstr(OpRType, 0, FnAddu), 32'd0,         0);
        addRow(32'd3,         32'd10,        mkInstr(OpRType, 0, FnSub),  32'hFFFF_FFF9, 0);
        addRow(32'h8000_0001, 32'd3,         mkInstr(OpSpecial2, 0, FnMul), 32'h8000_0003, 0);
        addRow(32'hF0F0_F0F0, 32'hFF00_FF00, mkInstr(OpRType, 0, FnAnd),  32'hF000_F000, 0);
        addRow(32'hF0F0_F0F0, 32'h0F00_000F, mkInstr(OpRType, 0, FnOr),   32'hFFF0_F0FF, 0);
        addRow(32'h0000_00FF, 32'h0000_FF00, mkInstr(OpRType, 0, FnNor),  32'hFFFF_0000, 0);
        addRow(32'hAAAA_5555, 32'hFFFF_0000, mkInstr(OpRType, 0, FnXor),  32'h5555_5555, 0);
        addRow(32'd1,         32'h0000_0F0F, mkInstr(OpRType, 4, FnSll),  32'h0000_F0F0, 0);
        addRow(32'd1,         32'h8000_0000, mkInstr(OpRType, 8, FnSrl),  32'h0080_0000, 0);
        addRow(32'hFFFF_FFFF, 32'd1,         mkInstr(OpRType, 0, FnSlt),  32'd1,         0);
        addRow(32'd1,         32'hFFFF_FFFF, mkInstr(OpRType, 0, FnSlt),  32'd0,         0);
        addRow(32'hFFFF_FFFB, 32'hFFFF_FFFB, mkInstr(OpSge, 0, 0),        32'd1,         0);
        addRow(32'hFFFF_FFFB, 32'd3,         mkInstr(OpSge, 0, 0),        32'd0,         0);
        addRow(32'd3,         32'hFFFF_FFFB, mkInstr(OpSgt, 0, 0),        32'd1,         0);
        addRow(32'd7,         32'd7,         mkInstr(OpSgt, 0, 0),        32'd0,         0);
        addRow(32'h8000_0000, 32'h7FFF_FFFF, mkInstr(OpSle, 0, 0),        32'd1,         0);
        addRow(32'd2,         32'd1,         mkInstr(OpSle, 0, 0),        32'd0,         0);
        addRow(32'd4,         32'd4,         mkInstr(OpSne, 0, 0),        32'd0,         0);
        addRow(32'h8000_0000, 32'd0,         mkInstr(OpSne, 0, 0),        32'd1,         0);
        nLegal = rows.size();
        addRow(32'd9,         32'd9,         mkInstr(6'h3F, 0, 0),        32'd0,         1);
        addRow(32'd9,         32'd9,         mkInstr(OpRType, 0, 6'h3F),  32'd0,         1);
        addRow(32'd9,         32'd9,         mkInstr(OpSpecial2, 0, 0),   32'd0,         1);
    endtask

    initial begin
        rowT rnd;
        void'($urandom(32'h3504));
        errors    = 0;
        checks    = 0;
        issued    = 0;
        lastInstr = '0;
        rstN      = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        repeat (10) @(posedge Clk);
        #1 rstN = 1'b1;

        // Reset state has zero set with done and illegal clear
        apbRead(RegStatus, 32'h1);
        apbRead(RegCount, 32'd0);
        apbRead(RegResult, 32'd0);

        buildTable();
        foreach (rows[i]) begin
            runRow(rows[i]);
        end

        // Random operands over the legal instructions
        for (int i = 0; i < RandomRows; i++) begin
            rnd.a           = $urandom;
            rnd.b           = $urandom;
            rnd.instr       = rows[$urandom % nLegal].instr;
            rnd.instr[10:6] = 5'($urandom);
            rnd.expResult   = refAlu(rnd.a, rnd.b, rnd.instr, rnd.illegal);
            rnd.expErr      = rnd.illegal;
            runRow(rnd);
        end

        ////////////////////
        // Register map
        ////////////////////
        apbRead(RegInstr, lastInstr);
        apbWrite(RegOpA, 32'h1357_9BDF, 1'b0);
        apbRead(RegOpA, 32'h1357_9BDF);
        apbWrite(RegOpB, 32'h2468_ACE0, 1'b0);
        apbRead(RegOpB, 32'h2468_ACE0);
        apbWrite(RegResult, 32'h1, 1'b1);     // Read-only offsets
        apbWrite(RegStatus, 32'h1, 1'b1);
        apbWrite(RegCount, 32'h1, 1'b1);
        apbWrite(5'h18, 32'h1, 1'b1);         // Unmapped
        apbXfer(1'b0, 5'h1C, '0);
        checkEq("pslverr on read 1c", rdErr, 1'b1);
        apbRead(RegCount, DataW'(issued));    // Illegal ones counted too

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- flist.f
src/mipsAluPkg.sv
src/aluOpIf.sv
src/aluResultIf.sv
src/aluDecode.sv
src/aluExecute.sv
src/aluResult.sv
src/mipsAluTop.sv
bench/mipsAlu_assertions.sv
bench/mipsAluTb.sv

//--- Bender.yml
package:
  name: mipsAlu

sources:
  - files:
      - src/mipsAluPkg.sv
      - src/aluOpIf.sv
      - src/aluResultIf.sv
      - src/aluDecode.sv
      - src/aluExecute.sv
      - src/aluResult.sv
      - src/mipsAluTop.sv
  - target: test
    files:
      - bench/mipsAlu_assertions.sv
      - bench/mipsAluTb.sv
